// File: sim.f
logic/graphPkg.sv
logic/topReceiver.sv
logic/leafEliminator.sv
logic/componentCounter.sv
logic/pcoeffAccumulator.sv
logic/pipelineControl.sv
logic/aggregatingPipeline.sv
test/aggregatingPipelineTb.sv

// File: run.sh
#!/bin/sh
# compile and run the testbench with Verilator
set -e

verilator --binary --timing --assert -f sim.f --top-module aggregatingPipelineTb \
    --Mdir obj_dir -o simv
./obj_dir/simv > sim.log
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
    exit 1
fi

// File: test/aggregatingPipelineTb.sv
`timescale 1ns/1ps
`default_nettype none

module aggregatingPipelineTb;
    import graphPkg::*;

    localparam int readyLimit = 40;     // cycles a bot may wait for botReady
    localparam int resultLimit = 80;    // cycles from last bot to its batch result

    typedef struct {
        string       name;
        logic [15:0] top;
        logic [15:0] bot;
        bit          last;
        int          gap;
    } entry_t;

    logic                                  clk;
    logic                                  rstN;
    logic                                  topBeat;
    logic [1:0]                            topChannel;
    logic                                  botValid;
    logic                                  botReady;
    botBeat_t                              bot;
    logic                                  resultsValid;
    logic [termCountBits+pcoeffWidth-1:0]  pcoeffSum;
    logic [termCountBits-1:0]              pcoeffCount;
    logic                                  eccStatus;

    entry_t stimulus[$];
    int     expSumQ[$];
    int     expCountQ[$];
    string  nameQ[$];
    string  lastName;
    int     mismatchErrors;
    int     otherErrors;
    int     batchesSeen;
    int     batchStalls;
    bit     validLast;
    bit     eccSeen;

    aggregatingPipeline dut (
        .clk         (clk),
        .rstN        (rstN),
        .topBeat     (topBeat),
        .topChannel  (topChannel),
        .botValid    (botValid),
        .botReady    (botReady),
        .bot         (bot),
        .resultsValid(resultsValid),
        .pcoeffSum   (pcoeffSum),
        .pcoeffCount (pcoeffCount),
        .eccStatus   (eccStatus)
    );

    always #10 clk = ~clk;

    // reference count by depth-first search on the unpruned graph
    function automatic int countComponents(logic [15:0] t, logic [15:0] b);
        logic [15:0] g;
        logic [15:0] seen;
        logic [3:0]  stack[$];
        logic [3:0]  n;
        logic [3:0]  m;
        int          count;
        g = t & ~b;
        seen = '0;
        count = 0;
        for (int i = 0; i < 16; i++) begin
            if (g[4'(i)] && !seen[4'(i)]) begin
                count++;
                seen[4'(i)] = 1'b1;
                stack.push_back(4'(i));
                while (stack.size() > 0) begin
                    n = stack.pop_back();
                    for (int d = 0; d < 4; d++) begin
                        m = n ^ (4'b1 << d);
                        if (g[m] && !seen[m]) begin
                            seen[m] = 1'b1;
                            stack.push_back(m);
                        end
                    end
                end
            end
        end
        return count;
    endfunction

    task automatic addEntry(string name, logic [15:0] t, logic [15:0] b, bit last, int gap);
        entry_t e;
        e.name = name;
        e.top = t;
        e.bot = b;
        e.last = last;
        e.gap = gap;
        stimulus.push_back(e);
    endtask

    // eight beats, low bit pair first
    task automatic loadTop(logic [15:0] t);
        for (int k = 0; k < 8; k++) begin
            topBeat = 1'b1;
            topChannel = 2'(t >> (2 * k));
            @(posedge clk);
            #1;
        end
        topBeat = 1'b0;
        topChannel = 2'b00;
    endtask

    task automatic sendBot(logic [15:0] g, bit last, int gap, output bit ok);
        int waited;
        ok = 1'b0;
        waited = 0;
        botValid = 1'b0;
        repeat (gap) begin
            @(posedge clk);
            #1;
        end
        botValid = 1'b1;
        bot.graph = g;
        bot.lastOfBatch = last;
        while (!ok && waited < readyLimit) begin
            @(negedge clk);
            if (botReady) begin
                ok = 1'b1;    // transfers on the coming edge
            end else begin
                batchStalls++;
            end
            @(posedge clk);
            #1;
            waited++;
        end
        botValid = 1'b0;
    endtask

    task automatic waitBatch(int target, output bit ok);
        int cycles;
        cycles = 0;
        while (batchesSeen < target && cycles < resultLimit) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        ok = batchesSeen >= target;
    endtask

    // outputs sampled mid-cycle
    always @(negedge clk) begin
        if (rstN) begin
            if (eccStatus && !eccSeen) begin
                eccSeen = 1'b1;
                otherErrors++;
                $display("eccStatus went high although no count exceeded the limit");
            end
            if (resultsValid) begin
                if (validLast) begin
                    otherErrors++;
                    $display("resultsValid stayed high for more than one cycle");
                end else if (expSumQ.size() == 0) begin
                    otherErrors++;
                    $display("resultsValid rose with no batch outstanding");
                end else begin
                    lastName = nameQ.pop_front();
                    if (int'(pcoeffSum) != expSumQ[0]) begin
                        mismatchErrors++;
                        $display("Mismatch %s pcoeffSum expected %0d actual %0d",
                                 lastName, expSumQ[0], pcoeffSum);
                    end
                    if (int'(pcoeffCount) != expCountQ[0]) begin
                        mismatchErrors++;
                        $display("Mismatch %s pcoeffCount expected %0d actual %0d",
                                 lastName, expCountQ[0], pcoeffCount);
                    end
                    void'(expSumQ.pop_front());
                    void'(expCountQ.pop_front());
                end
                batchesSeen++;
            end else if (validLast) begin
                if (pcoeffSum != '0) begin
                    mismatchErrors++;
                    $display("Mismatch %s clearedSum expected 0 actual %0d",
                             lastName, pcoeffSum);
                end
                if (pcoeffCount != '0) begin
                    mismatchErrors++;
                    $display("Mismatch %s clearedCount expected 0 actual %0d",
                             lastName, pcoeffCount);
                end
            end
            validLast = resultsValid;
        end
    end

    initial begin
        entry_t      e;
        logic [15:0] t;
        bit          ok;
        bit          aborted;
        bit          batchStart;
        bit          allZeroGap;
        int          batchSum;
        int          batchItems;
        int          batchesQueued;
        clk = 1'b0;
        rstN = 1'b0;
        topBeat = 1'b0;
        topChannel = 2'b00;
        botValid = 1'b0;
        bot = '0;
        mismatchErrors = 0;
        otherErrors = 0;
        batchesSeen = 0;
        batchStalls = 0;
        validLast = 1'b0;
        eccSeen = 1'b0;
        aborted = 1'b0;
        batchStart = 1'b1;
        allZeroGap = 1'b1;
        batchSum = 0;
        batchItems = 0;
        batchesQueued = 0;
        void'($urandom(16039));

        addEntry("afterReset", 16'hA5C3, 16'h0000, 1'b1, 0);
        addEntry("emptyGraph", 16'hFFFF, 16'hFFFF, 1'b1, 1);
        addEntry("fullCube", 16'hFFFF, 16'h0000, 1'b1, 0);
        addEntry("evenIsolated", 16'h9669, 16'h0000, 1'b1, 2);
        addEntry("pathLeaves", 16'h808B, 16'h0000, 1'b1, 0);
        addEntry("twoPaths", 16'hFFFF, 16'hAFFC, 1'b1, 0);
        addEntry("mixedEmpty", 16'hFFFF, 16'hFFFF, 1'b0, 0);
        addEntry("mixedCube", 16'hFFFF, 16'h0000, 1'b0, 1);
        addEntry("mixedIsolated", 16'hFFFF, 16'h6996, 1'b1, 0);
        for (int b = 0; b < 2; b++) begin
            t = 16'($urandom | $urandom);
            for (int k = 0; k < 6; k++) begin
                addEntry($sformatf("random%0d_%0d", b, k), t, 16'($urandom), k == 5,
                         $urandom_range(3, 0));
            end
        end
        t = 16'($urandom | $urandom);
        for (int k = 0; k < 8; k++) begin
            addEntry($sformatf("backToBack%0d", k), t, 16'($urandom), k == 7, 0);
        end

        // two edges with reset low
        @(negedge clk);
        if (botReady) begin
            otherErrors++;
            $display("botReady was high during reset");
        end
        @(posedge clk);
        #1;
        rstN = 1'b1;
        @(posedge clk);
        #1;
        @(negedge clk);
        if (!botReady || resultsValid || eccStatus) begin
            otherErrors++;
            $display("after reset expected botReady high, resultsValid and eccStatus low");
        end
        @(posedge clk);
        #1;

        for (int i = 0; i < stimulus.size() && !aborted; i++) begin
            e = stimulus[i];
            if (batchStart) begin
                loadTop(e.top);    // nothing in flight here
                batchSum = 0;
                batchItems = 0;
                batchStalls = 0;
                allZeroGap = 1'b1;
                batchStart = 1'b0;
            end
            sendBot(e.bot, e.last, e.gap, ok);
            if (!ok) begin
                otherErrors++;
                aborted = 1'b1;
                $display("timeout: botReady never rose for %s", e.name);
            end else begin
                batchSum += 1 << countComponents(e.top, e.bot);
                batchItems++;
                if (e.gap != 0) begin
                    allZeroGap = 1'b0;
                end
                if (e.last) begin
                    expSumQ.push_back(batchSum);
                    expCountQ.push_back(batchItems);
                    nameQ.push_back(e.name);
                    batchesQueued++;
                    waitBatch(batchesQueued, ok);
                    if (!ok) begin
                        otherErrors++;
                        aborted = 1'b1;
                        $display("timeout: no result for batch ending at %s", e.name);
                    end else if (allZeroGap && batchItems > 1 && batchStalls == 0) begin
                        otherErrors++;
                        $display("botReady never dropped in back-to-back batch %s", e.name);
                    end
                    batchStart = 1'b1;
                end
            end
        end
        @(posedge clk);
        #1;

        $display("errors: %0d mismatches, %0d other failures", mismatchErrors, otherErrors);
        if (mismatchErrors == 0 && otherErrors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: logic/aggregatingPipeline.sv
`timescale 1ns/1ps
`default_nettype none

module aggregatingPipeline (
    input  logic                                                    clk,
    input  logic                                                    rstN,
    input  logic                                                    topBeat,
    input  logic [1:0]                                              topChannel,
    input  logic                                                    botValid,
    output logic                                                    botReady,
    input  graphPkg::botBeat_t                                      bot,
    output logic                                                    resultsValid,
    output logic [graphPkg::termCountBits+graphPkg::pcoeffWidth-1:0] pcoeffSum,
    output logic [graphPkg::termCountBits-1:0]                      pcoeffCount,
    output logic                                                    eccStatus
);
    import graphPkg::*;

    logic         stageLoad;
    logic         countStart;
    logic         counterBusy;
    logic         countDone;
    graph_t       top;
    botBeat_t     staged;
    countResult_t countResult;

    pipelineControl control (
        .clk        (clk),
        .rstN       (rstN),
        .botValid   (botValid),
        .botReady   (botReady),
        .counterBusy(counterBusy),
        .countDone  (countDone),
        .stageLoad  (stageLoad),
        .countStart (countStart)
    );

    topReceiver receiver (
        .clk       (clk),
        .rstN      (rstN),
        .topBeat   (topBeat),
        .topChannel(topChannel),
        .top       (top)
    );

    leafEliminator eliminator (
        .clk      (clk),
        .rstN     (rstN),
        .stageLoad(stageLoad),
        .top      (top),
        .bot      (bot),
        .staged   (staged)
    );

    componentCounter counter (
        .clk       (clk),
        .rstN      (rstN),
        .countStart(countStart),
        .graphIn   (staged.graph),
        .lastIn    (staged.lastOfBatch),
        .busy      (counterBusy),
        .countDone (countDone),
        .result    (countResult)
    );

    pcoeffAccumulator #(
        .countBits(termCountBits)
    ) accumulator (
        .clk         (clk),
        .rstN        (rstN),
        .countDone   (countDone),
        .result      (countResult),
        .resultsValid(resultsValid),
        .pcoeffSum   (pcoeffSum),
        .pcoeffCount (pcoeffCount),
        .eccStatus   (eccStatus)
    );

endmodule

`default_nettype wire

// File: logic/pipelineControl.sv
`timescale 1ns/1ps
`default_nettype none

module pipelineControl (
    input  logic clk,
    input  logic rstN,
    input  logic botValid,
    output logic botReady,
    input  logic counterBusy,
    input  logic countDone,
    output logic stageLoad,
    output logic countStart
);

    logic running;      // low until the first edge out of reset
    logic stageFull;
    logic counting;     // our view of the counter, start to done

    assign countStart = stageFull && !counterBusy;
    assign botReady = running && (!stageFull || countStart);
    assign stageLoad = botValid && botReady;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            running <= 1'b0;
            stageFull <= 1'b0;
            counting <= 1'b0;
        end else begin
            running <= 1'b1;
            if (stageLoad) begin
                stageFull <= 1'b1;    // refill wins over drain
            end else if (countStart) begin
                stageFull <= 1'b0;
            end
            if (countStart) begin
                counting <= 1'b1;
            end else if (countDone) begin
                counting <= 1'b0;
            end
        end
    end

    // counter must have finished the previous item
    a_startWhenIdle: assert property (
        @(posedge clk) disable iff (!rstN)
        countStart |-> !counting
    );

    a_doneOnlyAfterStart: assert property (
        @(posedge clk) disable iff (!rstN)
        countDone |-> counting
    );

endmodule

`default_nettype wire

// File: logic/pcoeffAccumulator.sv
`timescale 1ns/1ps
`default_nettype none

module pcoeffAccumulator #(
    parameter int countBits = 8
) (
    input  logic                                      clk,
    input  logic                                      rstN,
    input  logic                                      countDone,
    input  graphPkg::countResult_t                    result,
    output logic                                      resultsValid,
    output logic [countBits+graphPkg::pcoeffWidth-1:0] pcoeffSum,
    output logic [countBits-1:0]                      pcoeffCount,
    output logic                                      eccStatus
);
    import graphPkg::*;

    logic [pcoeffWidth-1:0] term;

    assign term = pcoeffWidth'(1) << result.count;    // 2^C

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pcoeffSum <= '0;
            pcoeffCount <= '0;
            resultsValid <= 1'b0;
            eccStatus <= 1'b0;
        end else begin
            resultsValid <= countDone && result.lastOfBatch;
            if (countDone && result.count > countWidth'(maxComponents)) begin
                eccStatus <= 1'b1;    // sticky
            end
            if (resultsValid) begin
                // batch was reported last cycle, start over
                pcoeffSum <= countDone ? {{countBits{1'b0}}, term} : '0;
                pcoeffCount <= countDone ? countBits'(1) : '0;
            end else if (countDone) begin
                pcoeffSum <= pcoeffSum + {{countBits{1'b0}}, term};
                pcoeffCount <= pcoeffCount + 1'b1;
            end
        end
    end

    a_countNoWrap: assert property (
        @(posedge clk) disable iff (!rstN)
        countDone && !resultsValid |-> pcoeffCount != '1
    );

endmodule

`default_nettype wire

// File: logic/componentCounter.sv
`timescale 1ns/1ps
`default_nettype none

module componentCounter (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   countStart,
    input  graphPkg::graph_t       graphIn,
    input  logic                   lastIn,
    output logic                   busy,
    output logic                   countDone,
    output graphPkg::countResult_t result
);
    import graphPkg::*;

    graph_t       remaining;
    graph_t       seed;
    graph_t       component;
    countResult_t acc;

    // grow a frontier from the seed until it covers its whole component
    function automatic graph_t floodFill(graph_t start, graph_t g);
        graph_t frontier;
        frontier = start;
        for (int step = 0; step < nodeCount - 1; step++) begin
            frontier = (frontier | spread(frontier)) & g;
        end
        return frontier;
    endfunction

    assign seed = remaining & (~remaining + 1'b1);    // lowest remaining node
    assign component = floodFill(seed, remaining);

    // one component per cycle, then one more cycle to see the empty graph
    assign countDone = busy && remaining == '0;
    assign result = acc;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            busy <= 1'b0;
        end else if (countStart) begin
            busy <= 1'b1;
        end else if (countDone) begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (countStart) begin
            remaining <= graphIn;
            acc.count <= '0;
            acc.lastOfBatch <= lastIn;
        end else if (busy && remaining != '0) begin
            remaining <= remaining & ~component;
            acc.count <= acc.count + 1'b1;
        end
    end

    a_countBounded: assert property (
        @(posedge clk) disable iff (!rstN)
        busy |-> acc.count <= countWidth'(maxComponents)
    );

endmodule

`default_nettype wire

// File: logic/leafEliminator.sv
`timescale 1ns/1ps
`default_nettype none

module leafEliminator (
    input  logic               clk,
    input  logic               rstN,
    input  logic               stageLoad,
    input  graphPkg::graph_t   top,
    input  graphPkg::botBeat_t bot,
    output graphPkg::botBeat_t staged
);
    import graphPkg::*;

    graph_t masked;
    graph_t leaf;

    assign masked = top & ~bot.graph;

    // a downward leaf has exactly one neighbor, and that one sits below it.
    // judged on the unpruned graph so two leaves never remove each other
    always_comb begin
        int nbrs;
        int lower;
        leaf = '0;
        for (int i = 0; i < nodeCount; i++) begin
            nbrs = 0;
            lower = 0;
            for (int d = 0; d < dimCount; d++) begin
                if (masked[i ^ (1 << d)]) begin
                    nbrs++;
                    if (i[d]) begin
                        lower++;    // neighbor has bit d cleared
                    end
                end
            end
            leaf[i] = masked[i] && nbrs == 1 && lower == 1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            staged <= '0;
        end else if (stageLoad) begin
            staged.graph <= masked & ~leaf;
            staged.lastOfBatch <= bot.lastOfBatch;
        end
    end

endmodule

`default_nettype wire

// File: logic/topReceiver.sv
`timescale 1ns/1ps
`default_nettype none

module topReceiver (
    input  logic             clk,
    input  logic             rstN,
    input  logic             topBeat,
    input  logic [1:0]       topChannel,
    output graphPkg::graph_t top
);
    import graphPkg::*;

    // low bits arrive first, so shift right and enter at the top
    always_ff @(posedge clk) begin
        if (!rstN) begin
            top <= '0;
        end else if (topBeat) begin
            top <= {topChannel, top[nodeCount-1:2]};
        end
    end

endmodule

`default_nettype wire

// File: logic/graphPkg.sv
`default_nettype none

package graphPkg;

    localparam int nodeCount = 16;       // one node per bit
    localparam int dimCount = 4;
    localparam int maxComponents = 8;    // all even-parity nodes isolated
    localparam int countWidth = 4;
    localparam int pcoeffWidth = maxComponents + 1;
    localparam int termCountBits = 8;

    typedef logic [nodeCount-1:0] graph_t;

    typedef struct packed {
        graph_t graph;
        logic   lastOfBatch;
    } botBeat_t;

    typedef struct packed {
        logic [countWidth-1:0] count;
        logic                  lastOfBatch;
    } countResult_t;

    // every node with a hypercube neighbor in s
    function automatic graph_t spread(graph_t s);
        graph_t r;
        r = '0;
        for (int i = 0; i < nodeCount; i++) begin
            for (int d = 0; d < dimCount; d++) begin
                if (s[i ^ (1 << d)]) begin
                    r[i] = 1'b1;
                end
            end
        end
        return r;
    endfunction

endpackage

`default_nettype wire
